// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module ooo_issue_tb \
    -f verilog.f --Mdir obj_dir -o sim
out=$(./obj_dir/sim 2>&1 || true)
echo "$out"
if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// ==== verif/ooo_issue_chk.sv ====
`timescale 1ns/1ps

module ooo_issue_chk (
    input logic                clk,
    input logic                rst,
    input logic                dispatch_stall,
    input logic                alu_cdb_valid,
    input logic                mul_cdb_valid,
    input ooo_issue_pkg::tag_t alu_cdb_tag,
    input ooo_issue_pkg::tag_t mul_cdb_tag,
    input logic                mul_iss_valid,
    input ooo_issue_pkg::tag_t mul_iss_dst
);

    // First cycle out of reset is quiet
    a_reset_quiet: assert property (@(posedge clk)
        $past(rst) && !rst |-> !dispatch_stall && !alu_cdb_valid && !mul_cdb_valid)
        else $error("Stall or CDB valid high right after reset");

    a_mul_latency: assert property (@(posedge clk) disable iff (rst)
        mul_iss_valid |-> ##(ooo_issue_pkg::MUL_LATENCY)
            (mul_cdb_valid && mul_cdb_tag == $past(mul_iss_dst, ooo_issue_pkg::MUL_LATENCY)))
        else $error("Multiplier result missing after its fixed latency");

    a_cdb_tags_differ: assert property (@(posedge clk) disable iff (rst)
        alu_cdb_valid && mul_cdb_valid |-> alu_cdb_tag != mul_cdb_tag)
        else $error("Both CDBs carry the same tag");

endmodule : ooo_issue_chk

bind ooo_issue_top ooo_issue_chk chk (
    .clk, .rst, .dispatch_stall, .alu_cdb_valid, .mul_cdb_valid,
    .alu_cdb_tag, .mul_cdb_tag, .mul_iss_valid, .mul_iss_dst
);

// ==== verif/ooo_issue_monitor.sv ====
`timescale 1ns/1ps

module ooo_issue_monitor (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_valid,
    input  logic                      disp_en    [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::fu_class_t  disp_class [ooo_issue_pkg::DISPATCH_W],
    input  rv32_alu_pkg::alu_op_t     disp_op    [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::tag_t       disp_src1  [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::tag_t       disp_src2  [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::tag_t       disp_dst   [ooo_issue_pkg::DISPATCH_W],
    input  logic                      dispatch_stall,
    input  logic                      preload_en,
    input  ooo_issue_pkg::tag_t       preload_tag,
    input  rv32_alu_pkg::word_t       preload_data,
    input  logic                      cdb_valid  [ooo_issue_pkg::NUM_CDB],
    input  ooo_issue_pkg::tag_t       cdb_tag    [ooo_issue_pkg::NUM_CDB],
    input  rv32_alu_pkg::word_t       cdb_data   [ooo_issue_pkg::NUM_CDB],
    output int                        errors,
    output int                        completions,
    output logic                      stall_seen,
    output logic                      known      [ooo_issue_pkg::NUM_TAGS]
);

    // Model value per tag and the producer bookkeeping
    rv32_alu_pkg::word_t model   [ooo_issue_pkg::NUM_TAGS];
    logic                pending [ooo_issue_pkg::NUM_TAGS];
    logic                is_mul  [ooo_issue_pkg::NUM_TAGS];
    ooo_issue_pkg::tag_t src_a   [ooo_issue_pkg::NUM_TAGS];
    ooo_issue_pkg::tag_t src_b   [ooo_issue_pkg::NUM_TAGS];

    // RV32I semantics for the eight operations
    function automatic rv32_alu_pkg::word_t alu_model(input rv32_alu_pkg::alu_op_t op,
                                                      input rv32_alu_pkg::word_t a,
                                                      input rv32_alu_pkg::word_t b);
        case (op)
            rv32_alu_pkg::OP_ADD: return a + b;
            rv32_alu_pkg::OP_SUB: return a - b;
            rv32_alu_pkg::OP_AND: return a & b;
            rv32_alu_pkg::OP_OR:  return a | b;
            rv32_alu_pkg::OP_XOR: return a ^ b;
            rv32_alu_pkg::OP_SLL: return a << b[4:0];
            rv32_alu_pkg::OP_SRL: return a >> b[4:0];
            default:              return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic rv32_alu_pkg::word_t mul_model(input rv32_alu_pkg::word_t a,
                                                      input rv32_alu_pkg::word_t b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        return prod[31:0];
    endfunction

    initial begin
        errors      = 0;
        completions = 0;
        stall_seen  = 1'b0;
        for (int t = 0; t < ooo_issue_pkg::NUM_TAGS; t++) begin
            known[t]   = 1'b0;
            pending[t] = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < ooo_issue_pkg::NUM_TAGS; t++) begin
                known[t]   = 1'b0;
                pending[t] = 1'b0;
            end
        end else begin
            if (dispatch_stall) begin
                stall_seen = 1'b1;
            end
            for (int k = 0; k < ooo_issue_pkg::NUM_CDB; k++) begin
                if (cdb_valid[k]) begin
                    check_broadcast(k, cdb_tag[k], cdb_data[k]);
                end
            end
            if (preload_en) begin
                model[preload_tag] = preload_data;
                known[preload_tag] = 1'b1;
            end
            // Lane 0 first, lane 1 may read its result
            if (dispatch_valid && !dispatch_stall) begin
                for (int i = 0; i < ooo_issue_pkg::DISPATCH_W; i++) begin
                    if (disp_en[i]) begin
                        record_dispatch(i);
                    end
                end
            end
        end
    end

    task automatic record_dispatch(input int i);
        ooo_issue_pkg::tag_t d;
        d = disp_dst[i];
        if (pending[d] || known[d]) begin
            $display("Tag %0d dispatched while still in use", d);
            errors++;
        end
        is_mul[d]  = disp_class[i] == ooo_issue_pkg::FU_MUL;
        src_a[d]   = disp_src1[i];
        src_b[d]   = disp_src2[i];
        pending[d] = 1'b1;
        if (is_mul[d]) begin
            model[d] = mul_model(model[disp_src1[i]], model[disp_src2[i]]);
        end else begin
            model[d] = alu_model(disp_op[i], model[disp_src1[i]], model[disp_src2[i]]);
        end
    endtask

    task automatic check_broadcast(input int k, input ooo_issue_pkg::tag_t t,
                                   input rv32_alu_pkg::word_t data);
        if (!pending[t]) begin
            $display("Duplicate or unexpected completion of tag %0d on CDB %0d", t, k);
            errors++;
        end else begin
            if (is_mul[t] != (k == ooo_issue_pkg::CDB_MUL)) begin
                $display("Tag %0d completed on the wrong CDB %0d", t, k);
                errors++;
            end
            if (!known[src_a[t]] || !known[src_b[t]]) begin
                $display("Early completion of tag %0d before its sources", t);
                errors++;
            end
            if (data !== model[t]) begin
                $display("MISMATCH %s tag %0d expected %08h actual %08h",
                         is_mul[t] ? "mul_result" : "alu_result", t, model[t], data);
                errors++;
            end
            pending[t] = 1'b0;
            known[t]   = 1'b1;
            completions++;
        end
    endtask

endmodule : ooo_issue_monitor

// ==== verif/ooo_issue_tb.sv ====
`timescale 1ns/1ps

module ooo_issue_tb;

    localparam int W          = ooo_issue_pkg::DISPATCH_W;
    localparam int BATCHES    = 6;
    localparam int BATCH_OPS  = 24;
    // Per batch budget plus reset and preload overhead
    localparam int WDOG_CYCLES = 16 + BATCHES * (BATCH_OPS * 20 + 16 + 8 + 4);

    logic clk = 1'b0;
    logic rst;
    logic dispatch_valid;
    logic                      disp_en       [W];
    ooo_issue_pkg::fu_class_t  disp_class    [W];
    rv32_alu_pkg::alu_op_t     disp_op       [W];
    ooo_issue_pkg::tag_t       disp_src1     [W];
    logic                      disp_src1_rdy [W];
    ooo_issue_pkg::tag_t       disp_src2     [W];
    logic                      disp_src2_rdy [W];
    ooo_issue_pkg::tag_t       disp_dst      [W];
    logic                      preload_en;
    ooo_issue_pkg::tag_t       preload_tag;
    rv32_alu_pkg::word_t       preload_data;
    logic                      dispatch_stall;
    logic                      cdb_valid [ooo_issue_pkg::NUM_CDB];
    ooo_issue_pkg::tag_t       cdb_tag   [ooo_issue_pkg::NUM_CDB];
    rv32_alu_pkg::word_t       cdb_data  [ooo_issue_pkg::NUM_CDB];

    int   errors;
    int   completions;
    int   tb_errors;
    int   mul_occ_max;
    logic stall_seen;
    logic known [ooo_issue_pkg::NUM_TAGS];
    logic [15:0] lfsr;

    always #50 clk = ~clk;

    ooo_issue_top dut (.*);

    ooo_issue_monitor mon (
        .clk, .rst, .dispatch_valid, .disp_en, .disp_class, .disp_op, .disp_src1,
        .disp_src2, .disp_dst, .dispatch_stall, .preload_en, .preload_tag, .preload_data,
        .cdb_valid, .cdb_tag, .cdb_data, .errors, .completions, .stall_seen, .known
    );

    always @(posedge clk) begin
        if (int'(dut.mul_rs.occupancy) > mul_occ_max) begin
            mul_occ_max = int'(dut.mul_rs.occupancy);
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic hold_reset();
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #5 rst = 1'b0;
    endtask

    // Tags 6 and 7 give shifts by 0 and 31 and a negative compare operand
    task automatic preload_tags();
        logic [31:0] v;
        for (int t = 0; t < 8; t++) begin
            take_bits(32, v);
            if (t == 6) begin
                v[4:0] = 5'd0;
            end
            if (t == 7) begin
                v[31]  = 1'b1;
                v[4:0] = 5'd31;
            end
            preload_en   = 1'b1;
            preload_tag  = ooo_issue_pkg::tag_t'(t);
            preload_data = v;
            @(posedge clk);
            #5;
        end
        preload_en = 1'b0;
    endtask

    task automatic pick_src(input int t, output ooo_issue_pkg::tag_t s);
        logic [31:0] v;
        take_bits(1, v);
        if (v[0] || t == 8) begin
            take_bits(3, v);
            s = ooo_issue_pkg::tag_t'(v[2:0]);
        end else begin
            take_bits(5, v);
            s = ooo_issue_pkg::tag_t'(8 + int'(v[4:0]) % (t - 8));
        end
    endtask

    task automatic make_op(input int b, input int t, input int lane);
        logic [31:0] v;
        disp_en[lane]  = 1'b1;
        disp_dst[lane] = ooo_issue_pkg::tag_t'(t);
        disp_op[lane]  = rv32_alu_pkg::OP_ADD;
        if (b == 1 && t < 16) begin
            // Chain on tag 8 keeps the mul table filling
            disp_class[lane] = ooo_issue_pkg::FU_MUL;
            disp_src1[lane]  = (t == 8) ? 5'd1 : 5'd8;
            disp_src2[lane]  = ooo_issue_pkg::tag_t'(t % 8);
        end else if (b == 0 && t < 12) begin
            disp_class[lane] = ooo_issue_pkg::FU_ALU;
            disp_src1[lane]  = (t == 11) ? 5'd7 : 5'd3;
            disp_src2[lane]  = (t == 8) ? 5'd6 : ((t == 11) ? 5'd0 : 5'd7);
            disp_op[lane]    = (t == 9) ? rv32_alu_pkg::OP_SRL :
                               ((t == 11) ? rv32_alu_pkg::OP_SLT : rv32_alu_pkg::OP_SLL);
        end else begin
            take_bits(1, v);
            disp_class[lane] = ooo_issue_pkg::fu_class_t'(v[0]);
            take_bits(3, v);
            disp_op[lane] = rv32_alu_pkg::alu_op_t'(v[2:0]);
            pick_src(t, disp_src1[lane]);
            pick_src(t, disp_src2[lane]);
        end
    endtask

    // Holds the group through back-pressure, refreshing ready bits each cycle
    task automatic send_group();
        logic ok;
        dispatch_valid = 1'b1;
        forever begin
            for (int i = 0; i < W; i++) begin
                disp_src1_rdy[i] = known[disp_src1[i]];
                disp_src2_rdy[i] = known[disp_src2[i]];
            end
            @(negedge clk);
            ok = !dispatch_stall;
            @(posedge clk);
            #5;
            if (ok) begin
                break;
            end
        end
        dispatch_valid = 1'b0;
        for (int i = 0; i < W; i++) begin
            disp_en[i] = 1'b0;
        end
    endtask

    task automatic run_batch(input int b);
        logic [31:0] v;
        int t;
        logic pair;
        t = 8;
        while (t < ooo_issue_pkg::NUM_TAGS) begin
            make_op(b, t, 0);
            take_bits(1, v);
            pair = (v[0] || b == 1) && t < ooo_issue_pkg::NUM_TAGS - 1;
            if (pair) begin
                make_op(b, t + 1, 1);
            end
            send_group();
            t = t + (pair ? 2 : 1);
        end
        while (completions < (b + 1) * BATCH_OPS) begin
            @(posedge clk);
            #5;
        end
    endtask

    initial begin
        #(WDOG_CYCLES * 100);
        $display("Timeout: not all micro-ops completed within %0d cycles", WDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        lfsr           = 16'd10;
        tb_errors      = 0;
        mul_occ_max    = 0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        preload_en     = 1'b0;
        preload_tag    = '0;
        preload_data   = '0;
        for (int i = 0; i < W; i++) begin
            disp_en[i]       = 1'b0;
            disp_class[i]    = ooo_issue_pkg::FU_ALU;
            disp_op[i]       = rv32_alu_pkg::OP_ADD;
            disp_src1[i]     = '0;
            disp_src1_rdy[i] = 1'b0;
            disp_src2[i]     = '0;
            disp_src2_rdy[i] = 1'b0;
            disp_dst[i]      = '0;
        end
        for (int b = 0; b < BATCHES; b++) begin
            hold_reset();
            preload_tags();
            run_batch(b);
            if (b == 1 && (!stall_seen || mul_occ_max < 6)) begin
                $display("Back-pressure never reached: stall %0b, mul occupancy %0d",
                         stall_seen, mul_occ_max);
                tb_errors++;
            end
        end
        repeat (4) @(posedge clk);
        $display("errors=%0d completions=%0d", errors + tb_errors, completions);
        if (errors + tb_errors == 0 && completions == BATCHES * BATCH_OPS) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : ooo_issue_tb

// ==== verilog.f ====
verilog/rv32_alu_pkg.sv
verilog/ooo_issue_pkg.sv
verilog/reservation_table.sv
verilog/phys_reg_file.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/ooo_issue_top.sv
verif/ooo_issue_monitor.sv
verif/ooo_issue_chk.sv
verif/ooo_issue_tb.sv

// ==== verilog/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_valid,
    input  rv32_alu_pkg::alu_op_t issue_op,
    input  ooo_issue_pkg::tag_t   issue_dst,
    input  rv32_alu_pkg::word_t   issue_a,
    input  rv32_alu_pkg::word_t   issue_b,
    output logic                  cdb_valid,
    output ooo_issue_pkg::tag_t   cdb_tag,
    output rv32_alu_pkg::word_t   cdb_data
);

    rv32_alu_pkg::word_t result;
    logic [4:0]          shamt;

    assign shamt = issue_b[4:0];

    always_comb begin
        case (issue_op)
            rv32_alu_pkg::OP_ADD: result = issue_a + issue_b;
            rv32_alu_pkg::OP_SUB: result = issue_a - issue_b;
            rv32_alu_pkg::OP_AND: result = issue_a & issue_b;
            rv32_alu_pkg::OP_OR:  result = issue_a | issue_b;
            rv32_alu_pkg::OP_XOR: result = issue_a ^ issue_b;
            rv32_alu_pkg::OP_SLL: result = issue_a << shamt;
            rv32_alu_pkg::OP_SRL: result = issue_a >> shamt;
            // Signed compare
            rv32_alu_pkg::OP_SLT: result = {31'b0, $signed(issue_a) < $signed(issue_b)};
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            cdb_tag  <= issue_dst;
            cdb_data <= result;
        end
    end

endmodule : alu_unit

// ==== verilog/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  ooo_issue_pkg::tag_t issue_dst,
    input  rv32_alu_pkg::word_t issue_a,
    input  rv32_alu_pkg::word_t issue_b,
    output logic                cdb_valid,
    output ooo_issue_pkg::tag_t cdb_tag,
    output rv32_alu_pkg::word_t cdb_data
);

    // Stage 1 operands
    logic                s1_valid;
    ooo_issue_pkg::tag_t s1_tag;
    rv32_alu_pkg::word_t s1_a;
    rv32_alu_pkg::word_t s1_b;

    // Stage 2 partial products, the high by high term never reaches the low word
    logic                s2_valid;
    ooo_issue_pkg::tag_t s2_tag;
    logic [31:0]         s2_ll;
    logic [15:0]         s2_lh;
    logic [15:0]         s2_hl;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            s2_valid  <= s1_valid;
            cdb_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag <= issue_dst;
        s1_a   <= issue_a;
        s1_b   <= issue_b;

        s2_tag <= s1_tag;
        s2_ll  <= s1_a[15:0] * s1_b[15:0];
        s2_lh  <= 16'(s1_a[15:0] * s1_b[31:16]);
        s2_hl  <= 16'(s1_a[31:16] * s1_b[15:0]);

        // Cross terms only land in the upper half
        cdb_tag  <= s2_tag;
        cdb_data <= s2_ll + {s2_lh + s2_hl, 16'b0};
    end

endmodule : mul_unit

// ==== verilog/ooo_issue_pkg.sv ====
package ooo_issue_pkg;

    // Physical tags name both a register file slot and a CDB producer
    localparam int TAG_W    = 5;
    localparam int NUM_TAGS = 1 << TAG_W;

    localparam int RS_SIZE    = 8;
    localparam int DISPATCH_W = 2;

    // One CDB per function unit
    localparam int NUM_CDB = 2;
    localparam int CDB_ALU = 0;
    localparam int CDB_MUL = 1;

    // Cycles from multiplier issue to its CDB pulse
    localparam int MUL_LATENCY = 3;

    typedef logic [TAG_W-1:0] tag_t;

    // Occupancy needs to reach RS_SIZE itself
    typedef logic [$clog2(RS_SIZE):0] rs_count_t;

    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } fu_class_t;

endpackage : ooo_issue_pkg

// ==== verilog/ooo_issue_top.sv ====
`timescale 1ns/1ps

module ooo_issue_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_valid,
    input  logic                      disp_en       [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::fu_class_t  disp_class    [ooo_issue_pkg::DISPATCH_W],
    input  rv32_alu_pkg::alu_op_t     disp_op       [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::tag_t       disp_src1     [ooo_issue_pkg::DISPATCH_W],
    input  logic                      disp_src1_rdy [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::tag_t       disp_src2     [ooo_issue_pkg::DISPATCH_W],
    input  logic                      disp_src2_rdy [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::tag_t       disp_dst      [ooo_issue_pkg::DISPATCH_W],
    input  logic                      preload_en,
    input  ooo_issue_pkg::tag_t       preload_tag,
    input  rv32_alu_pkg::word_t       preload_data,
    output logic                      dispatch_stall,
    output logic                      cdb_valid     [ooo_issue_pkg::NUM_CDB],
    output ooo_issue_pkg::tag_t       cdb_tag       [ooo_issue_pkg::NUM_CDB],
    output rv32_alu_pkg::word_t       cdb_data      [ooo_issue_pkg::NUM_CDB]
);

    logic alu_full, mul_full, disp_go;
    // Both units take a new micro-op every cycle
    logic alu_ready, mul_ready;

    ooo_issue_pkg::tag_t   alu_rd_tag1, alu_rd_tag2, mul_rd_tag1, mul_rd_tag2;
    rv32_alu_pkg::word_t   alu_rd_data1, alu_rd_data2, mul_rd_data1, mul_rd_data2;

    logic                  alu_iss_valid, mul_iss_valid;
    rv32_alu_pkg::alu_op_t alu_iss_op;
    ooo_issue_pkg::tag_t   alu_iss_dst, mul_iss_dst;
    rv32_alu_pkg::word_t   alu_iss_a, alu_iss_b, mul_iss_a, mul_iss_b;

    logic                  alu_cdb_valid, mul_cdb_valid;
    ooo_issue_pkg::tag_t   alu_cdb_tag, mul_cdb_tag;
    rv32_alu_pkg::word_t   alu_cdb_data, mul_cdb_data;

    assign alu_ready      = 1'b1;
    assign mul_ready      = 1'b1;
    assign dispatch_stall = alu_full || mul_full;
    // A group is taken only when neither table is near full
    assign disp_go        = dispatch_valid && !dispatch_stall;

    reservation_table #(.TABLE_TYPE(ooo_issue_pkg::FU_ALU)) alu_rs (
        .clk, .rst, .dispatch_valid(disp_go), .disp_en, .disp_class, .disp_op,
        .disp_src1, .disp_src1_rdy, .disp_src2, .disp_src2_rdy, .disp_dst,
        .cdb_valid, .cdb_tag, .fu_ready(alu_ready),
        .rd_data1(alu_rd_data1), .rd_data2(alu_rd_data2), .table_full(alu_full),
        .rd_tag1(alu_rd_tag1), .rd_tag2(alu_rd_tag2), .issue_valid(alu_iss_valid),
        .issue_op(alu_iss_op), .issue_dst(alu_iss_dst), .issue_a(alu_iss_a),
        .issue_b(alu_iss_b)
    );

    // The multiplier has one function, so its op field stays open
    reservation_table #(.TABLE_TYPE(ooo_issue_pkg::FU_MUL)) mul_rs (
        .clk, .rst, .dispatch_valid(disp_go), .disp_en, .disp_class, .disp_op,
        .disp_src1, .disp_src1_rdy, .disp_src2, .disp_src2_rdy, .disp_dst,
        .cdb_valid, .cdb_tag, .fu_ready(mul_ready),
        .rd_data1(mul_rd_data1), .rd_data2(mul_rd_data2), .table_full(mul_full),
        .rd_tag1(mul_rd_tag1), .rd_tag2(mul_rd_tag2), .issue_valid(mul_iss_valid),
        .issue_op(), .issue_dst(mul_iss_dst), .issue_a(mul_iss_a), .issue_b(mul_iss_b)
    );

    phys_reg_file prf (
        .clk, .rst, .preload_en, .preload_tag, .preload_data,
        .cdb_valid, .cdb_tag, .cdb_data,
        .alu_rd_tag1, .alu_rd_tag2, .mul_rd_tag1, .mul_rd_tag2,
        .alu_rd_data1, .alu_rd_data2, .mul_rd_data1, .mul_rd_data2
    );

    alu_unit alu (
        .clk, .rst, .issue_valid(alu_iss_valid), .issue_op(alu_iss_op),
        .issue_dst(alu_iss_dst), .issue_a(alu_iss_a), .issue_b(alu_iss_b),
        .cdb_valid(alu_cdb_valid), .cdb_tag(alu_cdb_tag), .cdb_data(alu_cdb_data)
    );

    mul_unit mul (
        .clk, .rst, .issue_valid(mul_iss_valid), .issue_dst(mul_iss_dst),
        .issue_a(mul_iss_a), .issue_b(mul_iss_b),
        .cdb_valid(mul_cdb_valid), .cdb_tag(mul_cdb_tag), .cdb_data(mul_cdb_data)
    );

    // CDB slot per unit
    assign cdb_valid[ooo_issue_pkg::CDB_ALU] = alu_cdb_valid;
    assign cdb_tag[ooo_issue_pkg::CDB_ALU]   = alu_cdb_tag;
    assign cdb_data[ooo_issue_pkg::CDB_ALU]  = alu_cdb_data;
    assign cdb_valid[ooo_issue_pkg::CDB_MUL] = mul_cdb_valid;
    assign cdb_tag[ooo_issue_pkg::CDB_MUL]   = mul_cdb_tag;
    assign cdb_data[ooo_issue_pkg::CDB_MUL]  = mul_cdb_data;

endmodule : ooo_issue_top

// ==== verilog/phys_reg_file.sv ====
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic                preload_en,
    input  ooo_issue_pkg::tag_t preload_tag,
    input  rv32_alu_pkg::word_t preload_data,
    input  logic                cdb_valid [ooo_issue_pkg::NUM_CDB],
    input  ooo_issue_pkg::tag_t cdb_tag   [ooo_issue_pkg::NUM_CDB],
    input  rv32_alu_pkg::word_t cdb_data  [ooo_issue_pkg::NUM_CDB],
    input  ooo_issue_pkg::tag_t alu_rd_tag1,
    input  ooo_issue_pkg::tag_t alu_rd_tag2,
    input  ooo_issue_pkg::tag_t mul_rd_tag1,
    input  ooo_issue_pkg::tag_t mul_rd_tag2,
    output rv32_alu_pkg::word_t alu_rd_data1,
    output rv32_alu_pkg::word_t alu_rd_data2,
    output rv32_alu_pkg::word_t mul_rd_data1,
    output rv32_alu_pkg::word_t mul_rd_data2
);

    rv32_alu_pkg::word_t regs [ooo_issue_pkg::NUM_TAGS];

    // Later writes win, so the preload port sits first
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < ooo_issue_pkg::NUM_TAGS; t++) begin
                regs[t] <= '0;
            end
        end else begin
            if (preload_en) begin
                regs[preload_tag] <= preload_data;
            end
            for (int k = 0; k < ooo_issue_pkg::NUM_CDB; k++) begin
                if (cdb_valid[k]) begin
                    regs[cdb_tag[k]] <= cdb_data[k];
                end
            end
        end
    end

    assign alu_rd_data1 = regs[alu_rd_tag1];
    assign alu_rd_data2 = regs[alu_rd_tag2];
    assign mul_rd_data1 = regs[mul_rd_tag1];
    assign mul_rd_data2 = regs[mul_rd_tag2];

endmodule : phys_reg_file

// ==== verilog/reservation_table.sv ====
`timescale 1ns/1ps

module reservation_table #(
    parameter ooo_issue_pkg::fu_class_t TABLE_TYPE = ooo_issue_pkg::FU_ALU
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_valid,
    input  logic                      disp_en       [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::fu_class_t  disp_class    [ooo_issue_pkg::DISPATCH_W],
    input  rv32_alu_pkg::alu_op_t     disp_op       [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::tag_t       disp_src1     [ooo_issue_pkg::DISPATCH_W],
    input  logic                      disp_src1_rdy [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::tag_t       disp_src2     [ooo_issue_pkg::DISPATCH_W],
    input  logic                      disp_src2_rdy [ooo_issue_pkg::DISPATCH_W],
    input  ooo_issue_pkg::tag_t       disp_dst      [ooo_issue_pkg::DISPATCH_W],
    input  logic                      cdb_valid     [ooo_issue_pkg::NUM_CDB],
    input  ooo_issue_pkg::tag_t       cdb_tag       [ooo_issue_pkg::NUM_CDB],
    input  logic                      fu_ready,
    input  rv32_alu_pkg::word_t       rd_data1,
    input  rv32_alu_pkg::word_t       rd_data2,
    output logic                      table_full,
    output ooo_issue_pkg::tag_t       rd_tag1,
    output ooo_issue_pkg::tag_t       rd_tag2,
    output logic                      issue_valid,
    output rv32_alu_pkg::alu_op_t     issue_op,
    output ooo_issue_pkg::tag_t       issue_dst,
    output rv32_alu_pkg::word_t       issue_a,
    output rv32_alu_pkg::word_t       issue_b
);

    typedef logic [$clog2(ooo_issue_pkg::RS_SIZE)-1:0] rs_idx_t;

    // Entry state
    logic                  ent_full [ooo_issue_pkg::RS_SIZE];
    logic                  ent_met1 [ooo_issue_pkg::RS_SIZE];
    logic                  ent_met2 [ooo_issue_pkg::RS_SIZE];
    rv32_alu_pkg::alu_op_t ent_op   [ooo_issue_pkg::RS_SIZE];
    ooo_issue_pkg::tag_t   ent_src1 [ooo_issue_pkg::RS_SIZE];
    ooo_issue_pkg::tag_t   ent_src2 [ooo_issue_pkg::RS_SIZE];
    ooo_issue_pkg::tag_t   ent_dst  [ooo_issue_pkg::RS_SIZE];

    logic                     lane_ok   [ooo_issue_pkg::DISPATCH_W];
    rs_idx_t                  lane_slot [ooo_issue_pkg::DISPATCH_W];
    logic [ooo_issue_pkg::RS_SIZE-1:0] claimed;

    logic                     issue_any;
    logic                     issue_go;
    rs_idx_t                  issue_sel;
    ooo_issue_pkg::rs_count_t occupancy;

    // True when any CDB broadcasts this tag in the current cycle
    function automatic logic cdb_hit(input ooo_issue_pkg::tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < ooo_issue_pkg::NUM_CDB; k++) begin
            if (cdb_valid[k] && cdb_tag[k] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Each accepted lane of our class claims the lowest entry still free
    always_comb begin
        claimed = '0;
        for (int i = 0; i < ooo_issue_pkg::DISPATCH_W; i++) begin
            lane_ok[i]   = 1'b0;
            lane_slot[i] = '0;
            if (dispatch_valid && disp_en[i] && disp_class[i] == TABLE_TYPE) begin
                for (int j = 0; j < ooo_issue_pkg::RS_SIZE; j++) begin
                    if (!ent_full[j] && !claimed[j] && !lane_ok[i]) begin
                        lane_ok[i]   = 1'b1;
                        lane_slot[i] = rs_idx_t'(j);
                        claimed[j]   = 1'b1;
                    end
                end
            end
        end
    end

    // Lowest index with both sources met wins issue
    always_comb begin
        issue_any = 1'b0;
        issue_sel = '0;
        for (int j = ooo_issue_pkg::RS_SIZE - 1; j >= 0; j--) begin
            if (ent_full[j] && ent_met1[j] && ent_met2[j]) begin
                issue_any = 1'b1;
                issue_sel = rs_idx_t'(j);
            end
        end
    end

    assign issue_go = issue_any && fu_ready;
    assign rd_tag1  = ent_src1[issue_sel];
    assign rd_tag2  = ent_src2[issue_sel];

    always_comb begin
        occupancy = '0;
        for (int j = 0; j < ooo_issue_pkg::RS_SIZE; j++) begin
            occupancy = occupancy + ooo_issue_pkg::rs_count_t'(ent_full[j]);
        end
    end

    // Leaves room for one whole dispatch group
    assign table_full = occupancy >=
        ooo_issue_pkg::rs_count_t'(ooo_issue_pkg::RS_SIZE - ooo_issue_pkg::DISPATCH_W);

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
            for (int j = 0; j < ooo_issue_pkg::RS_SIZE; j++) begin
                ent_full[j] <= 1'b0;
                ent_met1[j] <= 1'b0;
                ent_met2[j] <= 1'b0;
            end
        end else begin
            issue_valid <= issue_go;
            // Wakeup of waiting sources
            for (int j = 0; j < ooo_issue_pkg::RS_SIZE; j++) begin
                if (cdb_hit(ent_src1[j])) begin
                    ent_met1[j] <= 1'b1;
                end
                if (cdb_hit(ent_src2[j])) begin
                    ent_met2[j] <= 1'b1;
                end
            end
            // New entries also catch a broadcast in their dispatch cycle
            for (int i = 0; i < ooo_issue_pkg::DISPATCH_W; i++) begin
                if (lane_ok[i]) begin
                    ent_full[lane_slot[i]] <= 1'b1;
                    ent_met1[lane_slot[i]] <= disp_src1_rdy[i] || cdb_hit(disp_src1[i]);
                    ent_met2[lane_slot[i]] <= disp_src2_rdy[i] || cdb_hit(disp_src2[i]);
                end
            end
            if (issue_go) begin
                ent_full[issue_sel] <= 1'b0;
            end
        end
    end

    // Payload of entries and of the unit input register
    always_ff @(posedge clk) begin
        for (int i = 0; i < ooo_issue_pkg::DISPATCH_W; i++) begin
            if (lane_ok[i]) begin
                ent_op[lane_slot[i]]   <= disp_op[i];
                ent_src1[lane_slot[i]] <= disp_src1[i];
                ent_src2[lane_slot[i]] <= disp_src2[i];
                ent_dst[lane_slot[i]]  <= disp_dst[i];
            end
        end
        if (issue_go) begin
            issue_op  <= ent_op[issue_sel];
            issue_dst <= ent_dst[issue_sel];
            issue_a   <= rd_data1;
            issue_b   <= rd_data2;
        end
    end

endmodule : reservation_table

// ==== verilog/rv32_alu_pkg.sv ====
package rv32_alu_pkg;

    // Data path width of the execute units
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // ALU function select, carried in every micro-op
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_SLT = 3'd7
    } alu_op_t;

endpackage : rv32_alu_pkg
